// File: common/bpu_pkg.sv
package bpu_pkg;

    // datapath
    localparam int XLEN        = 32;
    localparam int GHIST_W     = 16;

    // bimodal base table indexed by pc[9:1]
    localparam int BIM_ENTRIES = 512;
    localparam int BIM_IDX_W   = 9;

    // tagged tables
    localparam int TT_ENTRIES  = 256;
    localparam int TT_IDX_W    = 8;
    localparam int TAG_W       = 10;
    localparam int PTAG_W      = 6;     // upper tag bits used for lookup match

    // btb indexed by pc[9:2] with tag pc[31:10]
    localparam int BTB_ENTRIES = 256;
    localparam int BTB_IDX_W   = 8;
    localparam int BTB_TAG_W   = 22;

    // return address stack
    localparam int RAS_DEPTH   = 64;
    localparam int RAS_IDX_W   = 6;
    localparam int RAS_PTR_W   = 7;     // extra bit so a full stack reads as 64

    // two-bit saturating counter
    typedef logic [1:0] ctr_t;

    localparam ctr_t CTR_STRONG_NT = 2'd0;
    localparam ctr_t CTR_WEAK_NT   = 2'd1;
    localparam ctr_t CTR_WEAK_T    = 2'd2;
    localparam ctr_t CTR_STRONG_T  = 2'd3;

    typedef enum logic [1:0] {
        OP_BRANCH,
        OP_JAL,
        OP_JALR,
        OP_OTHER
    } opcode_e;

    typedef enum logic [1:0] {
        PROV_BIM,
        PROV_T0,
        PROV_T1
    } provider_e;

    // one saturating step toward the resolved outcome
    function automatic ctr_t ctr_next(input ctr_t cur, input logic taken);
        if (taken) begin
            return (cur == CTR_STRONG_T) ? cur : ctr_t'(cur + 2'd1);
        end
        return (cur == CTR_STRONG_NT) ? cur : ctr_t'(cur - 2'd1);
    endfunction

endpackage

// File: design/inst_predecode.sv
module inst_predecode (
    input  logic [bpu_pkg::XLEN-1:0] inst_i,
    output bpu_pkg::opcode_e         kind_o,
    output logic                     is_ret_o,
    output logic [bpu_pkg::XLEN-1:0] b_imm_o,
    output logic [bpu_pkg::XLEN-1:0] j_imm_o
);

    logic [4:0] rs1;
    logic       link_rs1;

    always_comb begin
        case (inst_i[6:0])
            7'b1100011: kind_o = bpu_pkg::OP_BRANCH;
            7'b1101111: kind_o = bpu_pkg::OP_JAL;
            7'b1100111: kind_o = bpu_pkg::OP_JALR;
            default:    kind_o = bpu_pkg::OP_OTHER;
        endcase
    end

    assign rs1      = inst_i[19:15];
    assign link_rs1 = (rs1 == 5'd1) || (rs1 == 5'd5);  // ra or t0

    // jalr through a link register; rd and imm are left to the caller
    assign is_ret_o = (kind_o == bpu_pkg::OP_JALR) && link_rs1;

    // B-type offset
    assign b_imm_o = {{(bpu_pkg::XLEN-12){inst_i[31]}},
                      inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};

    // J-type offset
    assign j_imm_o = {{(bpu_pkg::XLEN-20){inst_i[31]}},
                      inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

endmodule

// File: tage/bimodal_table.sv
module bimodal_table (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [bpu_pkg::XLEN-1:0] rd_pc_i,
    input  logic                     upd_valid_i,
    input  logic [bpu_pkg::XLEN-1:0] upd_pc_i,
    input  logic                     upd_taken_i,
    output logic                     pred_taken_o
);

    bpu_pkg::ctr_t ctr_q [bpu_pkg::BIM_ENTRIES];

    logic [bpu_pkg::BIM_IDX_W-1:0] rd_idx;
    logic [bpu_pkg::BIM_IDX_W-1:0] upd_idx;

    // halfword granularity so compressed slots get their own entry
    assign rd_idx  = rd_pc_i[bpu_pkg::BIM_IDX_W:1];
    assign upd_idx = upd_pc_i[bpu_pkg::BIM_IDX_W:1];

    assign pred_taken_o = ctr_q[rd_idx][1];  // msb is the direction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < bpu_pkg::BIM_ENTRIES; i++) begin
                ctr_q[i] <= bpu_pkg::CTR_WEAK_NT;
            end
        end else if (upd_valid_i) begin
            ctr_q[upd_idx] <= bpu_pkg::ctr_next(ctr_q[upd_idx], upd_taken_i);
        end
    end

endmodule

// File: tage/tagged_table.sv
module tagged_table (
    input  logic                         clk,
    input  logic                         rst,

    // lookup
    input  logic [bpu_pkg::TT_IDX_W-1:0] rd_idx_i,
    input  logic [bpu_pkg::TAG_W-1:0]    rd_tag_i,
    output logic                         hit_o,
    output logic                         pred_taken_o,

    // update
    input  logic [bpu_pkg::TT_IDX_W-1:0] upd_idx_i,
    input  logic [bpu_pkg::TAG_W-1:0]    upd_tag_i,
    output logic                         upd_hit_o,
    output logic                         upd_full_match_o,
    input  logic                         train_i,
    input  logic                         set_strong_i,
    input  logic                         alloc_i,
    input  logic                         upd_taken_i
);

    logic [bpu_pkg::TAG_W-1:0] tag_q [bpu_pkg::TT_ENTRIES];
    bpu_pkg::ctr_t             ctr_q [bpu_pkg::TT_ENTRIES];

    logic [bpu_pkg::TAG_W-1:0] rd_entry_tag;
    logic [bpu_pkg::TAG_W-1:0] upd_entry_tag;
    bpu_pkg::ctr_t             upd_ctr;

    assign rd_entry_tag  = tag_q[rd_idx_i];
    assign upd_entry_tag = tag_q[upd_idx_i];
    assign upd_ctr       = ctr_q[upd_idx_i];

    // partial match on the upper tag bits only
    assign hit_o = rd_entry_tag[bpu_pkg::TAG_W-1 -: bpu_pkg::PTAG_W]
                   == rd_tag_i[bpu_pkg::TAG_W-1 -: bpu_pkg::PTAG_W];
    assign pred_taken_o = ctr_q[rd_idx_i][1];

    assign upd_hit_o = upd_entry_tag[bpu_pkg::TAG_W-1 -: bpu_pkg::PTAG_W]
                       == upd_tag_i[bpu_pkg::TAG_W-1 -: bpu_pkg::PTAG_W];
    assign upd_full_match_o = (upd_entry_tag == upd_tag_i);  // gates allocation

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < bpu_pkg::TT_ENTRIES; i++) begin
                tag_q[i] <= '0;
                ctr_q[i] <= bpu_pkg::CTR_WEAK_NT;
            end
        end else if (alloc_i) begin
            // new entry starts weak in the resolved direction
            tag_q[upd_idx_i] <= upd_tag_i;
            ctr_q[upd_idx_i] <= upd_taken_i ? bpu_pkg::CTR_WEAK_T : bpu_pkg::CTR_WEAK_NT;
        end else if (set_strong_i) begin
            ctr_q[upd_idx_i] <= upd_taken_i ? bpu_pkg::CTR_STRONG_T
                                            : bpu_pkg::CTR_STRONG_NT;
        end else if (train_i) begin
            ctr_q[upd_idx_i] <= bpu_pkg::ctr_next(upd_ctr, upd_taken_i);
        end
    end

endmodule

// File: tage/tage_predictor.sv
module tage_predictor (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [bpu_pkg::XLEN-1:0]    pc_i,
    input  logic [bpu_pkg::GHIST_W-1:0] ghist_i,
    input  logic                        upd_valid_i,
    input  logic [bpu_pkg::XLEN-1:0]    upd_pc_i,
    input  logic [bpu_pkg::GHIST_W-1:0] upd_hist_i,
    input  logic                        upd_taken_i,
    input  logic                        upd_correct_i,
    output logic                        pred_taken_o
);

    logic [bpu_pkg::TT_IDX_W-1:0] t0_idx, t1_idx, t0_upd_idx, t1_upd_idx;
    logic [bpu_pkg::TAG_W-1:0]    t0_tag, t1_tag, t0_upd_tag, t1_upd_tag;

    logic bim_taken, t0_taken, t1_taken;
    logic t0_hit, t1_hit, t0_upd_hit, t1_upd_hit;
    logic t0_full, t1_full;
    logic t0_train, t1_train, t0_strong, t1_strong, t0_alloc, t1_alloc;
    logic mispredict;

    bpu_pkg::provider_e lk_prov;
    bpu_pkg::provider_e upd_prov;

    // t0 folds the low history half into the index, t1 the high half
    assign t0_idx = pc_i[7:0] ^ ghist_i[7:0];
    assign t0_tag = pc_i[17:8] ^ ghist_i[15:6];
    assign t1_idx = pc_i[7:0] ^ ghist_i[15:8];
    assign t1_tag = pc_i[17:8] ^ {2'b00, ghist_i[7:0]};

    // same hashes on the ex side with the history the branch saw
    assign t0_upd_idx = upd_pc_i[7:0] ^ upd_hist_i[7:0];
    assign t0_upd_tag = upd_pc_i[17:8] ^ upd_hist_i[15:6];
    assign t1_upd_idx = upd_pc_i[7:0] ^ upd_hist_i[15:8];
    assign t1_upd_tag = upd_pc_i[17:8] ^ {2'b00, upd_hist_i[7:0]};

    // longest history wins
    assign lk_prov  = t1_hit ? bpu_pkg::PROV_T1 :
                      t0_hit ? bpu_pkg::PROV_T0 : bpu_pkg::PROV_BIM;
    assign upd_prov = t1_upd_hit ? bpu_pkg::PROV_T1 :
                      t0_upd_hit ? bpu_pkg::PROV_T0 : bpu_pkg::PROV_BIM;

    always_comb begin
        case (lk_prov)
            bpu_pkg::PROV_T1: pred_taken_o = t1_taken;
            bpu_pkg::PROV_T0: pred_taken_o = t0_taken;
            default:          pred_taken_o = bim_taken;
        endcase
    end

    assign mispredict = upd_valid_i && !upd_correct_i;

    assign t1_train  = upd_valid_i && upd_correct_i && (upd_prov == bpu_pkg::PROV_T1);
    assign t0_train  = upd_valid_i && upd_correct_i && (upd_prov == bpu_pkg::PROV_T0);
    assign t1_strong = mispredict && (upd_prov == bpu_pkg::PROV_T1);
    assign t0_strong = mispredict && (upd_prov == bpu_pkg::PROV_T0);

    // base table was wrong so t1 is tried first and t0 second
    assign t1_alloc = mispredict && (upd_prov == bpu_pkg::PROV_BIM) && !t1_full;
    assign t0_alloc = mispredict && (upd_prov == bpu_pkg::PROV_BIM) && t1_full && !t0_full;

    bimodal_table u_bim (
        .clk          (clk),
        .rst          (rst),
        .rd_pc_i      (pc_i),
        .upd_valid_i  (upd_valid_i),
        .upd_pc_i     (upd_pc_i),
        .upd_taken_i  (upd_taken_i),
        .pred_taken_o (bim_taken)
    );

    tagged_table u_t0 (
        .clk              (clk),
        .rst              (rst),
        .rd_idx_i         (t0_idx),
        .rd_tag_i         (t0_tag),
        .hit_o            (t0_hit),
        .pred_taken_o     (t0_taken),
        .upd_idx_i        (t0_upd_idx),
        .upd_tag_i        (t0_upd_tag),
        .upd_hit_o        (t0_upd_hit),
        .upd_full_match_o (t0_full),
        .train_i          (t0_train),
        .set_strong_i     (t0_strong),
        .alloc_i          (t0_alloc),
        .upd_taken_i      (upd_taken_i)
    );

    tagged_table u_t1 (
        .clk              (clk),
        .rst              (rst),
        .rd_idx_i         (t1_idx),
        .rd_tag_i         (t1_tag),
        .hit_o            (t1_hit),
        .pred_taken_o     (t1_taken),
        .upd_idx_i        (t1_upd_idx),
        .upd_tag_i        (t1_upd_tag),
        .upd_hit_o        (t1_upd_hit),
        .upd_full_match_o (t1_full),
        .train_i          (t1_train),
        .set_strong_i     (t1_strong),
        .alloc_i          (t1_alloc),
        .upd_taken_i      (upd_taken_i)
    );

endmodule

// File: btb/btb.sv
module btb (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [bpu_pkg::XLEN-1:0] pc_i,
    output logic                     hit_o,
    output logic [bpu_pkg::XLEN-1:0] target_o,
    input  logic                     upd_valid_i,
    input  logic [bpu_pkg::XLEN-1:0] upd_pc_i,
    input  logic [bpu_pkg::XLEN-1:0] upd_target_i
);

    logic [bpu_pkg::BTB_TAG_W-1:0] tag_q    [bpu_pkg::BTB_ENTRIES];
    logic [bpu_pkg::XLEN-1:0]      target_q [bpu_pkg::BTB_ENTRIES];
    logic [bpu_pkg::BTB_ENTRIES-1:0] valid_q;

    logic [bpu_pkg::BTB_IDX_W-1:0] rd_idx;
    logic [bpu_pkg::BTB_IDX_W-1:0] upd_idx;

    assign rd_idx  = pc_i[bpu_pkg::BTB_IDX_W+1:2];  // word aligned
    assign upd_idx = upd_pc_i[bpu_pkg::BTB_IDX_W+1:2];

    assign hit_o = valid_q[rd_idx]
                   && (tag_q[rd_idx] == pc_i[bpu_pkg::XLEN-1 -: bpu_pkg::BTB_TAG_W]);
    assign target_o = target_q[rd_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (upd_valid_i) begin
            valid_q[upd_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (upd_valid_i) begin
            tag_q[upd_idx]    <= upd_pc_i[bpu_pkg::XLEN-1 -: bpu_pkg::BTB_TAG_W];
            target_q[upd_idx] <= upd_target_i;
        end
    end

endmodule

// File: ras/return_stack.sv
module return_stack (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     pop_i,
    input  logic                     push_i,
    input  logic [bpu_pkg::XLEN-1:0] push_data_i,
    output logic                     nonempty_o,
    output logic [bpu_pkg::XLEN-1:0] top_o
);

    logic [bpu_pkg::XLEN-1:0] stack_q [bpu_pkg::RAS_DEPTH];

    logic [bpu_pkg::RAS_PTR_W-1:0] ptr_q;      // next free slot
    logic [bpu_pkg::RAS_PTR_W-1:0] ptr_top;
    logic [bpu_pkg::RAS_PTR_W-1:0] ptr_popped;
    logic                          do_push;

    assign ptr_top    = ptr_q - 1'b1;
    assign nonempty_o = (ptr_q != '0);
    assign top_o      = stack_q[ptr_top[bpu_pkg::RAS_IDX_W-1:0]];

    // pop first, then the push lands in the freed slot
    assign ptr_popped = (pop_i && nonempty_o) ? ptr_top : ptr_q;
    assign do_push    = push_i && (ptr_popped < bpu_pkg::RAS_PTR_W'(bpu_pkg::RAS_DEPTH));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ptr_q <= '0;
        end else if (do_push) begin
            ptr_q <= ptr_popped + 1'b1;
        end else begin
            ptr_q <= ptr_popped;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            stack_q[ptr_popped[bpu_pkg::RAS_IDX_W-1:0]] <= push_data_i;
        end
    end

endmodule

// File: design/bpu.sv
module bpu (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [bpu_pkg::XLEN-1:0]    if_pc_i,
    input  logic [bpu_pkg::XLEN-1:0]    if_inst_i,
    input  logic                        ex_branch_valid_i,
    input  logic                        ex_branch_taken_i,
    input  logic                        ex_pdt_true_i,
    input  logic [bpu_pkg::XLEN-1:0]    ex_pc_i,
    input  logic [bpu_pkg::GHIST_W-1:0] ex_history_i,
    input  logic [bpu_pkg::XLEN-1:0]    ex_target_i,
    input  logic [bpu_pkg::XLEN-1:0]    ex_inst_i,
    input  logic                        id_ras_push_valid_i,
    input  logic [bpu_pkg::XLEN-1:0]    id_ras_push_data_i,
    input  logic                        ex_stall_i,
    input  logic                        id_stall_i,
    output logic                        is_cti_o,
    output logic                        pdt_taken_o,
    output logic [bpu_pkg::XLEN-1:0]    pdt_pc_o,
    output logic [bpu_pkg::GHIST_W-1:0] history_o
);

    logic [bpu_pkg::GHIST_W-1:0] ghist_q;

    bpu_pkg::opcode_e         if_kind;
    logic                     if_link_jalr, if_is_ret, ex_is_ret;
    logic [bpu_pkg::XLEN-1:0] if_b_imm, if_j_imm, pc_plus4;
    logic                     dir_taken, btb_hit, ras_nonempty;
    logic [bpu_pkg::XLEN-1:0] btb_target, ras_top;
    logic                     ras_pop, ras_push;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ghist_q <= '0;
        end else if (ex_branch_valid_i) begin
            ghist_q <= {ghist_q[bpu_pkg::GHIST_W-2:0], ex_branch_taken_i};
        end
    end

    assign history_o = ghist_q;

    inst_predecode u_if_dec (
        .inst_i   (if_inst_i),
        .kind_o   (if_kind),
        .is_ret_o (if_link_jalr),
        .b_imm_o  (if_b_imm),
        .j_imm_o  (if_j_imm)
    );

    // ex side only needs the return test
    inst_predecode u_ex_dec (
        .inst_i   (ex_inst_i),
        .kind_o   (),
        .is_ret_o (ex_is_ret),
        .b_imm_o  (),
        .j_imm_o  ()
    );

    // a true return also has rd x0 and a zero offset
    assign if_is_ret = if_link_jalr && (if_inst_i[11:7] == 5'd0) && (if_inst_i[31:20] == 12'd0);

    assign ras_pop  = ex_branch_valid_i && ex_branch_taken_i && !ex_stall_i && ex_is_ret;
    assign ras_push = id_ras_push_valid_i && !ex_stall_i && !id_stall_i;

    tage_predictor u_tage (
        .clk           (clk),
        .rst           (rst),
        .pc_i          (if_pc_i),
        .ghist_i       (ghist_q),
        .upd_valid_i   (ex_branch_valid_i),
        .upd_pc_i      (ex_pc_i),
        .upd_hist_i    (ex_history_i),
        .upd_taken_i   (ex_branch_taken_i),
        .upd_correct_i (ex_pdt_true_i),
        .pred_taken_o  (dir_taken)
    );

    btb u_btb (
        .clk          (clk),
        .rst          (rst),
        .pc_i         (if_pc_i),
        .hit_o        (btb_hit),
        .target_o     (btb_target),
        .upd_valid_i  (ex_branch_valid_i && ex_branch_taken_i),  // taken branches only
        .upd_pc_i     (ex_pc_i),
        .upd_target_i (ex_target_i)
    );

    return_stack u_ras (
        .clk         (clk),
        .rst         (rst),
        .pop_i       (ras_pop),
        .push_i      (ras_push),
        .push_data_i (id_ras_push_data_i),
        .nonempty_o  (ras_nonempty),
        .top_o       (ras_top)
    );

    assign pc_plus4 = if_pc_i + bpu_pkg::XLEN'(4);

    always_comb begin
        is_cti_o    = 1'b0;
        pdt_taken_o = 1'b0;
        pdt_pc_o    = pc_plus4;
        if (if_is_ret) begin
            is_cti_o = 1'b1;
            if (ras_push) begin            // call in ID right now bypasses the stack
                pdt_taken_o = 1'b1;
                pdt_pc_o    = id_ras_push_data_i;
            end else if (ras_nonempty) begin
                pdt_taken_o = 1'b1;
                pdt_pc_o    = ras_top;
            end
        end else begin
            case (if_kind)
                bpu_pkg::OP_JAL: begin
                    is_cti_o    = 1'b1;
                    pdt_taken_o = 1'b1;
                    pdt_pc_o    = btb_hit ? btb_target : if_pc_i + if_j_imm;
                end
                bpu_pkg::OP_BRANCH, bpu_pkg::OP_JALR: begin
                    is_cti_o = 1'b1;
                    if (dir_taken && btb_hit) begin
                        pdt_taken_o = 1'b1;
                        pdt_pc_o    = btb_target;
                    end else if (dir_taken && (if_kind == bpu_pkg::OP_BRANCH)) begin
                        pdt_taken_o = 1'b1;
                        pdt_pc_o    = if_pc_i + if_b_imm;
                    end
                    // jalr with no btb entry has no known target so it falls through
                end
                default: ;
            endcase
        end
    end

endmodule

// File: sim/bpu_chk.sv
module bpu_chk (
    input logic        clk,
    input logic        rst,
    input logic [31:0] if_pc_i,
    input logic        is_cti_i,
    input logic        pdt_taken_i,
    input logic [31:0] pdt_pc_i,
    input logic [15:0] history_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // a taken prediction needs a control transfer
    a_taken_is_cti: assert property (@(posedge clk) disable iff (rst)
        pdt_taken_i |-> is_cti_i)
        else $error("pdt_taken_o set without is_cti_o");

    a_seq_pc: assert property (@(posedge clk) disable iff (rst)
        !is_cti_i |-> (pdt_pc_i == if_pc_i + 32'd4))
        else $error("sequential instruction not predicted to pc plus 4");

    a_history_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(history_i))
        else $error("history_o unknown after reset");

endmodule

bind bpu bpu_chk u_bpu_chk (
    .clk         (clk),
    .rst         (rst),
    .if_pc_i     (if_pc_i),
    .is_cti_i    (is_cti_o),
    .pdt_taken_i (pdt_taken_o),
    .pdt_pc_i    (pdt_pc_o),
    .history_i   (history_o)
);

// File: sim/bpu_tb.sv
module bpu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD      = 4;
    localparam int RST_CYCLES      = 16;
    localparam int TEST_CYCLES     = 200;  // rough length of all directed tests
    localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES;
    localparam logic [31:0] SEED   = 32'h4cbe_1dac;

    localparam logic [31:0] INST_NOP = 32'h0000_0013;  // addi x0, x0, 0
    localparam logic [31:0] INST_RET = 32'h0000_8067;  // jalr x0, 0(x1)

    // pc[17:12] all ones keeps cold tagged lookups from matching
    localparam logic [31:0] PC_A  = 32'h0003_F104;
    localparam logic [31:0] PC_B  = 32'h0003_F208;
    localparam logic [31:0] PC_C  = 32'h0003_F30C;
    localparam logic [31:0] PC_D  = 32'h0003_F410;
    localparam logic [31:0] PC_E  = 32'h0003_F514;
    localparam logic [31:0] TGT_A = 32'h0000_2468;
    localparam logic [31:0] TGT_C = 32'h0001_3570;
    localparam logic [31:0] TGT_D = 32'h0002_0abc;

    logic        clk, rst;
    logic [31:0] if_pc, if_inst, ex_pc, ex_target, ex_inst, push_data;
    logic [15:0] ex_history;
    logic        ex_valid, ex_taken, ex_correct, push_valid, ex_stall, id_stall;
    logic        is_cti, pdt_taken;
    logic [31:0] pdt_pc;
    logic [15:0] history;

    logic [15:0] hist_model;  // shadow of the global history
    int          errors;
    int          checks;

    bpu u_bpu (
        .clk                 (clk),
        .rst                 (rst),
        .if_pc_i             (if_pc),
        .if_inst_i           (if_inst),
        .ex_branch_valid_i   (ex_valid),
        .ex_branch_taken_i   (ex_taken),
        .ex_pdt_true_i       (ex_correct),
        .ex_pc_i             (ex_pc),
        .ex_history_i        (ex_history),
        .ex_target_i         (ex_target),
        .ex_inst_i           (ex_inst),
        .id_ras_push_valid_i (push_valid),
        .id_ras_push_data_i  (push_data),
        .ex_stall_i          (ex_stall),
        .id_stall_i          (id_stall),
        .is_cti_o            (is_cti),
        .pdt_taken_o         (pdt_taken),
        .pdt_pc_o            (pdt_pc),
        .history_o           (history)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    // beq x0, x0 with a byte offset
    function automatic logic [31:0] make_beq(input logic [12:0] off);
        return {off[12], off[10:5], 5'd0, 5'd0, 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    // jal x1 with a byte offset
    function automatic logic [31:0] make_jal(input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b1101111};
    endfunction

    task automatic check_eq(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL t=%0t %s: got %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // present an IF word, check the prediction, then move on one cycle
    task automatic check_pred(input string name, input logic [31:0] pc,
                              input logic [31:0] inst, input logic exp_cti,
                              input logic exp_taken, input logic [31:0] exp_pc);
        if_pc   = pc;
        if_inst = inst;
        #1;
        check_eq({name, " is_cti_o"}, 32'(is_cti), 32'(exp_cti));
        check_eq({name, " pdt_taken_o"}, 32'(pdt_taken), 32'(exp_taken));
        check_eq({name, " pdt_pc_o"}, pdt_pc, exp_pc);
        next_cycle();
    endtask

    // one-cycle resolved branch from EX
    task automatic send_update(input logic [31:0] pc, input logic [31:0] inst,
                               input logic taken, input logic correct,
                               input logic [31:0] target, input logic [15:0] hist);
        ex_valid   = 1'b1;
        ex_taken   = taken;
        ex_correct = correct;
        ex_pc      = pc;
        ex_inst    = inst;
        ex_target  = target;
        ex_history = hist;
        next_cycle();
        ex_valid   = 1'b0;
        ex_taken   = 1'b0;
        ex_correct = 1'b0;
        hist_model = {hist_model[14:0], taken};
        check_eq("history_o", 32'(history), 32'(hist_model));
    endtask

    task automatic push_ras(input logic [31:0] data);
        push_valid = 1'b1;
        push_data  = data;
        next_cycle();
        push_valid = 1'b0;
    endtask

    task automatic test_reset_state();
        check_pred("alu", PC_B, INST_NOP, 1'b0, 1'b0, PC_B + 32'd4);
        check_pred("cold branch", PC_A, make_beq(13'd16), 1'b1, 1'b0, PC_A + 32'd4);
        check_eq("history_o after reset", 32'(history), 32'd0);
    endtask

    task automatic test_bimodal_btb();
        send_update(PC_A, make_beq(13'd16), 1'b1, 1'b1, TGT_A, hist_model);
        send_update(PC_A, make_beq(13'd16), 1'b1, 1'b1, TGT_A, hist_model);
        check_pred("trained branch", PC_A, make_beq(13'd16), 1'b1, 1'b1, TGT_A);
        check_pred("untrained branch", PC_B, make_beq(13'd16), 1'b1, 1'b0, PC_B + 32'd4);
    endtask

    task automatic test_jal();
        check_pred("jal cold", PC_C, make_jal(21'h00800), 1'b1, 1'b1, PC_C + 32'h800);
        send_update(PC_C, make_jal(21'h00800), 1'b1, 1'b1, TGT_C, hist_model);
        check_pred("jal btb", PC_C, make_jal(21'h00800), 1'b1, 1'b1, TGT_C);
    endtask

    task automatic test_tage_alloc();
        send_update(PC_D, make_beq(13'd16), 1'b0, 1'b1, PC_D + 32'd16, hist_model);
        send_update(PC_D, make_beq(13'd16), 1'b0, 1'b1, PC_D + 32'd16, hist_model);
        check_pred("bimodal not taken", PC_D, make_beq(13'd16), 1'b1, 1'b0, PC_D + 32'd4);
        // update hashed with the history that the next lookup will see
        send_update(PC_D, make_beq(13'd16), 1'b1, 1'b0, TGT_D, {hist_model[14:0], 1'b1});
        check_pred("t1 allocated", PC_D, make_beq(13'd16), 1'b1, 1'b1, TGT_D);
    endtask

    task automatic test_return_stack();
        logic [31:0] d1, d2, d3, d4;
        d1 = $urandom & 32'hffff_fffc;
        d2 = $urandom & 32'hffff_fffc;
        d3 = $urandom & 32'hffff_fffc;
        d4 = $urandom & 32'hffff_fffc;
        check_pred("ret empty", PC_E, INST_RET, 1'b1, 1'b0, PC_E + 32'd4);
        push_ras(d1);
        push_ras(d2);
        check_pred("ret top", PC_E, INST_RET, 1'b1, 1'b1, d2);
        send_update(PC_E, INST_RET, 1'b1, 1'b1, d2, hist_model);  // pops d2
        check_pred("ret after pop", PC_E, INST_RET, 1'b1, 1'b1, d1);
        push_valid = 1'b1;
        push_data  = d3;
        id_stall   = 1'b1;
        check_pred("ret during id stall", PC_E, INST_RET, 1'b1, 1'b1, d1);
        push_valid = 1'b0;
        id_stall   = 1'b0;
        check_pred("ret after stalled push", PC_E, INST_RET, 1'b1, 1'b1, d1);
        push_valid = 1'b1;
        push_data  = d4;
        check_pred("ret bypass", PC_E, INST_RET, 1'b1, 1'b1, d4);
        push_valid = 1'b0;
        check_pred("ret pushed", PC_E, INST_RET, 1'b1, 1'b1, d4);
    endtask

    initial begin
        void'($urandom(SEED));
        errors     = 0;
        checks     = 0;
        hist_model = '0;
        rst        = 1'b1;
        if_pc      = '0;
        if_inst    = INST_NOP;
        ex_valid   = 1'b0;
        ex_taken   = 1'b0;
        ex_correct = 1'b0;
        ex_pc      = '0;
        ex_history = '0;
        ex_target  = '0;
        ex_inst    = INST_NOP;
        push_valid = 1'b0;
        push_data  = '0;
        ex_stall   = 1'b0;
        id_stall   = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        test_reset_state();
        test_bimodal_btb();
        test_jal();
        test_tage_alloc();
        test_return_stack();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
common/bpu_pkg.sv
design/inst_predecode.sv
tage/bimodal_table.sv
tage/tagged_table.sv
tage/tage_predictor.sv
btb/btb.sv
ras/return_stack.sv
design/bpu.sv
sim/bpu_chk.sv
sim/bpu_tb.sv

// File: run.sh
#!/bin/sh
# compile and run bpu_tb with verilator, pass only if the log shows the pass line
cd "$(dirname "$0")" || exit 1
LOG=sim.log

if ! verilator --binary --timing --assert -f build.f --top-module bpu_tb \
        -Mdir obj_dir -o Vbpu_tb; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/Vbpu_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST OK" "$LOG"; then
    exit 0
fi
echo "simulation did not report success"
exit 1
